//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_debug
FILELIST  = tb.f
OBJ_DIR   = obj_dir
RUN_ARGS  = +verilator+error+limit+1000
PASS_MSG  = sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/debug_consts.svh
`ifndef DEBUG_CONSTS_SVH
`define DEBUG_CONSTS_SVH

// Memory and register bank sizes seen by the debug unit
`define DBG_IM_DEPTH      256   // Instruction bytes per load
`define DBG_DM_DEPTH      128   // Data memory bytes per dump
`define DBG_RB_DEPTH      32    // Registers per dump

// Bytes in one PC or register word
`define DBG_WORD_BYTES    4

// Command bytes received over the UART
`define DBG_CMD_LOAD      8'd1  // Load instruction memory
`define DBG_CMD_RUN       8'd2  // Continuous execution
`define DBG_CMD_STEP_MODE 8'd3
`define DBG_CMD_SEND_REGS 8'd4
`define DBG_CMD_SEND_MEM  8'd5
`define DBG_CMD_SEND_PC   8'd6
`define DBG_CMD_STEP      8'd7  // One instruction, then full dump
`define DBG_CMD_CONTINUE  8'd8

`endif

//--- common/debug_pkg.sv
`default_nettype none

`include "debug_consts.svh"

package debug_pkg;

    // Payload widths
    typedef logic [7:0] byte_t;
    typedef logic [8*`DBG_WORD_BYTES-1:0] word_t;

    // Address widths follow the depths
    typedef logic [$clog2(`DBG_IM_DEPTH)-1:0] im_addr_t;
    typedef logic [$clog2(`DBG_DM_DEPTH)-1:0] dm_addr_t;
    typedef logic [$clog2(`DBG_RB_DEPTH)-1:0] rb_addr_t;

    // Byte 0 is the most significant one of a word
    typedef logic [$clog2(`DBG_WORD_BYTES)-1:0] byte_idx_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_IM,
        READY,
        RUN,
        STEP_MODE,
        DUMP_PC,
        DUMP_DM,
        DUMP_RB
    } dbg_state_t;

    // Which value a dump streams out
    typedef enum logic [1:0] {
        SRC_PC,
        SRC_DM,
        SRC_RB
    } dump_src_t;

endpackage

`default_nettype wire

//--- common/dump_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dump_ctrl_if;

    // State machine to counter and serializer
    logic                  dump_start;   // One-cycle pulse
    debug_pkg::dump_src_t  dump_src;     // Held until dump_done
    logic                  load_step;    // One pulse per instruction byte written

    // Counter outputs
    debug_pkg::dm_addr_t   word_idx;     // Wide enough for the largest dump
    debug_pkg::byte_idx_t  byte_idx;
    logic                  byte_req;
    logic                  dump_done;
    logic                  load_last;    // Load address at the last location

    // Transmitter done, qualified by a byte in flight
    logic                  byte_sent;

    modport fsm (
        output dump_start, dump_src, load_step,
        input  dump_done, load_last
    );

    modport counter (
        input  dump_start, dump_src, load_step, byte_sent,
        output word_idx, byte_idx, byte_req, dump_done, load_last
    );

    modport serializer (
        input  byte_req, dump_src, byte_idx,
        output byte_sent
    );

endinterface

`default_nettype wire

//--- debug_unit/debug_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_consts.svh"

module debug_fsm (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_rx_valid,
    input  debug_pkg::byte_t      i_rx_data,
    input  logic                  i_halt,
    dump_ctrl_if.fsm              ctrl,
    output debug_pkg::dbg_state_t o_state,
    output logic                  o_im_we,
    output debug_pkg::byte_t      o_im_data,
    output logic                  o_cpu_enable,
    output logic                  o_step,
    output logic                  o_step_mode,
    output logic                  o_dm_re,
    output logic                  o_rb_re
);

    debug_pkg::dbg_state_t state, next_state;
    debug_pkg::dbg_state_t ret_state, next_ret;    // Where a dump goes back to
    debug_pkg::dump_src_t  src_q, next_src;
    logic                  start_q, start_next;
    logic                  im_we_q;
    debug_pkg::byte_t      im_data_q;
    logic                  step_q, step_next;
    logic                  step_mode_q;

    always_comb begin
        next_state = state;
        next_ret   = ret_state;
        next_src   = src_q;
        start_next = 1'b0;
        step_next  = 1'b0;
        case (state)
            debug_pkg::IDLE: begin
                if (i_rx_valid) begin
                    case (i_rx_data)
                        `DBG_CMD_LOAD:      next_state = debug_pkg::LOAD_IM;
                        `DBG_CMD_STEP_MODE: next_state = debug_pkg::STEP_MODE;
                        `DBG_CMD_SEND_REGS: begin
                            next_state = debug_pkg::DUMP_RB;
                            next_src   = debug_pkg::SRC_RB;
                            next_ret   = debug_pkg::IDLE;
                            start_next = 1'b1;
                        end
                        `DBG_CMD_SEND_MEM: begin
                            next_state = debug_pkg::DUMP_DM;
                            next_src   = debug_pkg::SRC_DM;
                            next_ret   = debug_pkg::IDLE;
                            start_next = 1'b1;
                        end
                        `DBG_CMD_SEND_PC: begin
                            next_state = debug_pkg::DUMP_PC;
                            next_src   = debug_pkg::SRC_PC;
                            next_ret   = debug_pkg::IDLE;
                            start_next = 1'b1;
                        end
                        default: ;  // Unknown codes are dropped
                    endcase
                end
            end
            debug_pkg::LOAD_IM: begin
                if (im_we_q && ctrl.load_last)
                    next_state = debug_pkg::READY;
            end
            debug_pkg::READY: begin
                if (i_rx_valid && i_rx_data == `DBG_CMD_RUN)
                    next_state = debug_pkg::RUN;
                else if (i_rx_valid && i_rx_data == `DBG_CMD_STEP_MODE)
                    next_state = debug_pkg::STEP_MODE;
            end
            debug_pkg::RUN: begin
                if (i_halt)
                    next_state = debug_pkg::IDLE;
            end
            debug_pkg::STEP_MODE: begin
                if (i_rx_valid && i_rx_data == `DBG_CMD_STEP) begin
                    // Step, then dump PC, memory and registers in turn
                    step_next  = 1'b1;
                    next_state = debug_pkg::DUMP_PC;
                    next_src   = debug_pkg::SRC_PC;
                    next_ret   = debug_pkg::STEP_MODE;
                    start_next = 1'b1;
                end else if (i_rx_valid && i_rx_data == `DBG_CMD_CONTINUE) begin
                    next_state = debug_pkg::RUN;
                end
            end
            debug_pkg::DUMP_PC: begin
                if (ctrl.dump_done && ret_state == debug_pkg::STEP_MODE) begin
                    next_state = debug_pkg::DUMP_DM;
                    next_src   = debug_pkg::SRC_DM;
                    start_next = 1'b1;
                end else if (ctrl.dump_done) begin
                    next_state = ret_state;
                end
            end
            debug_pkg::DUMP_DM: begin
                if (ctrl.dump_done && ret_state == debug_pkg::STEP_MODE) begin
                    next_state = debug_pkg::DUMP_RB;
                    next_src   = debug_pkg::SRC_RB;
                    start_next = 1'b1;
                end else if (ctrl.dump_done) begin
                    next_state = ret_state;
                end
            end
            debug_pkg::DUMP_RB: begin
                if (ctrl.dump_done)
                    next_state = ret_state;    // Last dump of a step chain too
            end
            default: next_state = debug_pkg::IDLE;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state       <= debug_pkg::IDLE;
            ret_state   <= debug_pkg::IDLE;
            src_q       <= debug_pkg::SRC_PC;
            start_q     <= 1'b0;
            im_we_q     <= 1'b0;
            step_q      <= 1'b0;
            step_mode_q <= 1'b0;
        end else begin
            state     <= next_state;
            ret_state <= next_ret;
            src_q     <= next_src;
            start_q   <= start_next;
            step_q    <= step_next;
            // No write once the last address has gone out
            im_we_q   <= (state == debug_pkg::LOAD_IM) && i_rx_valid &&
                         !(im_we_q && ctrl.load_last);
            if (next_state == debug_pkg::STEP_MODE)
                step_mode_q <= 1'b1;
            else if (next_state == debug_pkg::RUN || next_state == debug_pkg::IDLE)
                step_mode_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == debug_pkg::LOAD_IM && i_rx_valid)
            im_data_q <= i_rx_data;
    end

    assign ctrl.dump_start = start_q;
    assign ctrl.dump_src   = src_q;
    assign ctrl.load_step  = im_we_q;      // Counter advances after each write

    assign o_state      = state;
    assign o_im_we      = im_we_q;
    assign o_im_data    = im_data_q;
    assign o_cpu_enable = (state == debug_pkg::RUN);
    assign o_step       = step_q;
    assign o_step_mode  = step_mode_q;
    assign o_dm_re      = (state == debug_pkg::DUMP_DM);
    assign o_rb_re      = (state == debug_pkg::DUMP_RB);

endmodule

`default_nettype wire

//--- debug_unit/dump_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_consts.svh"

module dump_counter (
    input  logic                i_clock,
    input  logic                i_reset,
    dump_ctrl_if.counter        ctrl,
    output debug_pkg::im_addr_t o_im_addr,
    output debug_pkg::dm_addr_t o_dm_addr,
    output debug_pkg::rb_addr_t o_rb_addr
);

    debug_pkg::im_addr_t  im_addr;
    debug_pkg::dm_addr_t  word_idx;
    debug_pkg::byte_idx_t byte_idx;
    debug_pkg::dm_addr_t  last_word;
    debug_pkg::byte_idx_t last_byte;
    logic                 byte_req;
    logic                 dump_done;

    // Wrap points per source
    always_comb begin
        case (ctrl.dump_src)
            debug_pkg::SRC_PC: begin
                last_word = '0;    // Single word
                last_byte = debug_pkg::byte_idx_t'(`DBG_WORD_BYTES - 1);
            end
            debug_pkg::SRC_DM: begin
                last_word = debug_pkg::dm_addr_t'(`DBG_DM_DEPTH - 1);
                last_byte = '0;    // One byte per address
            end
            default: begin
                last_word = debug_pkg::dm_addr_t'(`DBG_RB_DEPTH - 1);
                last_byte = debug_pkg::byte_idx_t'(`DBG_WORD_BYTES - 1);
            end
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            im_addr   <= '0;
            word_idx  <= '0;
            byte_idx  <= '0;
            byte_req  <= 1'b0;
            dump_done <= 1'b0;
        end else begin
            byte_req  <= 1'b0;
            dump_done <= 1'b0;
            if (ctrl.load_step)
                im_addr <= im_addr + 1'b1;    // Wraps back to 0 after the last byte
            if (ctrl.dump_start) begin
                word_idx <= '0;
                byte_idx <= '0;
                byte_req <= 1'b1;
            end else if (ctrl.byte_sent) begin
                if (byte_idx != last_byte) begin
                    byte_idx <= byte_idx + 1'b1;
                    byte_req <= 1'b1;
                end else if (word_idx != last_word) begin
                    byte_idx <= '0;
                    word_idx <= word_idx + 1'b1;
                    byte_req <= 1'b1;
                end else begin
                    dump_done <= 1'b1;
                end
            end
        end
    end

    assign ctrl.load_last = (im_addr == debug_pkg::im_addr_t'(`DBG_IM_DEPTH - 1));
    assign ctrl.word_idx  = word_idx;
    assign ctrl.byte_idx  = byte_idx;
    assign ctrl.byte_req  = byte_req;
    assign ctrl.dump_done = dump_done;

    assign o_im_addr = im_addr;
    assign o_dm_addr = ctrl.word_idx;
    assign o_rb_addr = debug_pkg::rb_addr_t'(ctrl.word_idx);   // Low bits index the bank

endmodule

`default_nettype wire

//--- debug_unit/tx_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_consts.svh"

module tx_serializer (
    input  logic              i_clock,
    input  logic              i_reset,
    dump_ctrl_if.serializer   ctrl,
    input  debug_pkg::word_t  i_pc_value,
    input  debug_pkg::byte_t  i_dm_data,
    input  debug_pkg::word_t  i_rb_data,
    input  logic              i_tx_done,
    output debug_pkg::byte_t  o_tx_data,
    output logic              o_tx_start
);

    debug_pkg::byte_t sel_byte;
    debug_pkg::byte_t tx_data_q;
    logic             tx_start_q;
    logic             in_flight;    // Start sent, done not yet seen

    // Most significant byte first
    function automatic debug_pkg::byte_t pick_byte(input debug_pkg::word_t word,
                                                   input debug_pkg::byte_idx_t idx);
        int unsigned shift;
        shift = 8 * (`DBG_WORD_BYTES - 1 - int'(idx));
        return debug_pkg::byte_t'(word >> shift);
    endfunction

    always_comb begin
        case (ctrl.dump_src)
            debug_pkg::SRC_PC: sel_byte = pick_byte(i_pc_value, ctrl.byte_idx);
            debug_pkg::SRC_DM: sel_byte = i_dm_data;
            default:           sel_byte = pick_byte(i_rb_data, ctrl.byte_idx);
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            tx_start_q <= 1'b0;
            in_flight  <= 1'b0;
        end else begin
            tx_start_q <= ctrl.byte_req;
            if (ctrl.byte_req)
                in_flight <= 1'b1;
            else if (i_tx_done)
                in_flight <= 1'b0;
        end
    end

    always_ff @(posedge i_clock) begin
        if (ctrl.byte_req)
            tx_data_q <= sel_byte;    // Held for the whole transfer
    end

    assign ctrl.byte_sent = i_tx_done && in_flight;   // Stray done pulses are dropped
    assign o_tx_data      = tx_data_q;
    assign o_tx_start     = tx_start_q;

endmodule

`default_nettype wire

//--- design/debug_top.sv
`timescale 1ns/1ps
`default_nettype none

module debug_top (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_rx_valid,
    input  debug_pkg::byte_t      i_rx_data,
    input  logic                  i_halt,
    input  debug_pkg::word_t      i_pc_value,
    input  debug_pkg::byte_t      i_dm_data,
    input  debug_pkg::word_t      i_rb_data,
    input  logic                  i_tx_done,
    output debug_pkg::dbg_state_t o_state,
    output logic                  o_im_we,
    output debug_pkg::byte_t      o_im_data,
    output debug_pkg::im_addr_t   o_im_addr,
    output logic                  o_cpu_enable,
    output logic                  o_step,
    output logic                  o_step_mode,
    output logic                  o_dm_re,
    output debug_pkg::dm_addr_t   o_dm_addr,
    output logic                  o_rb_re,
    output debug_pkg::rb_addr_t   o_rb_addr,
    output debug_pkg::byte_t      o_tx_data,
    output logic                  o_tx_start
);

    dump_ctrl_if u_dump_ctrl ();

    // Command decode and mode control
    debug_fsm u_fsm (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_rx_valid   (i_rx_valid),
        .i_rx_data    (i_rx_data),
        .i_halt       (i_halt),
        .ctrl         (u_dump_ctrl.fsm),
        .o_state      (o_state),
        .o_im_we      (o_im_we),
        .o_im_data    (o_im_data),
        .o_cpu_enable (o_cpu_enable),
        .o_step       (o_step),
        .o_step_mode  (o_step_mode),
        .o_dm_re      (o_dm_re),
        .o_rb_re      (o_rb_re)
    );

    dump_counter u_counter (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .ctrl      (u_dump_ctrl.counter),
        .o_im_addr (o_im_addr),
        .o_dm_addr (o_dm_addr),
        .o_rb_addr (o_rb_addr)
    );

    // Byte stream to the UART transmitter
    tx_serializer u_serializer (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .ctrl       (u_dump_ctrl.serializer),
        .i_pc_value (i_pc_value),
        .i_dm_data  (i_dm_data),
        .i_rb_data  (i_rb_data),
        .i_tx_done  (i_tx_done),
        .o_tx_data  (o_tx_data),
        .o_tx_start (o_tx_start)
    );

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
common/debug_pkg.sv
common/dump_ctrl_if.sv
debug_unit/debug_fsm.sv
debug_unit/dump_counter.sv
debug_unit/tx_serializer.sv
design/debug_top.sv
verif/tb_clock.sv
verif/debug_checker.sv
verif/tb_debug.sv

//--- verif/debug_checker.sv
`timescale 1ns/1ps
`default_nettype none

module debug_checker (
    input logic                  i_clock,
    input logic                  i_reset,
    input debug_pkg::dbg_state_t i_state,
    input logic                  i_tx_start,
    input logic                  i_im_we,
    input logic                  i_cpu_enable,
    input logic                  i_step
);

    int unsigned fail_count = 0;    // Failed assertions so far

    tx_start_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
        i_tx_start |=> !i_tx_start)
    else begin
        fail_count++;
        $error("transmit start held for more than one cycle");
    end

    // Bytes only go out while a dump is running
    tx_start_in_dump: assert property (@(posedge i_clock) disable iff (i_reset)
        i_tx_start |-> (i_state inside {debug_pkg::DUMP_PC, debug_pkg::DUMP_DM,
                                        debug_pkg::DUMP_RB}))
    else begin
        fail_count++;
        $error("transmit start outside a dump state");
    end

    im_we_in_load: assert property (@(posedge i_clock) disable iff (i_reset)
        i_im_we |-> (i_state == debug_pkg::LOAD_IM))
    else begin
        fail_count++;
        $error("instruction write outside the load state");
    end

    run_without_tx: assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_cpu_enable && i_tx_start))
    else begin
        fail_count++;
        $error("transmit start while the processor runs");
    end

    step_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
        i_step |=> !i_step)    // One instruction per step command
    else begin
        fail_count++;
        $error("step held for more than one cycle");
    end

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic o_clock,
    output logic o_reset
);

    localparam real HALF_PERIOD = 20.0;    // 40 ns clock

    initial begin
        o_clock = 1'b0;
        forever #(HALF_PERIOD) o_clock = ~o_clock;
    end

    // Held over the first four rising edges
    initial begin
        o_reset = 1'b1;
        repeat (4) @(posedge o_clock);
        o_reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/tb_debug.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_consts.svh"

module tb_debug;

    localparam int DUMP_LIMIT = 3000;    // Cycles for the largest single dump
    localparam int CHAIN_LIMIT = 8000;   // PC, memory and registers back to back

    logic                  clock;
    logic                  reset;
    logic                  rx_valid;
    debug_pkg::byte_t      rx_data;
    logic                  halt;
    debug_pkg::word_t      pc_value;
    debug_pkg::byte_t      dm_data;
    debug_pkg::word_t      rb_data;
    logic                  tx_done;
    debug_pkg::dbg_state_t state;
    logic                  im_we;
    debug_pkg::byte_t      im_data;
    debug_pkg::im_addr_t   im_addr;
    logic                  cpu_enable;
    logic                  step;
    logic                  step_mode;
    logic                  dm_re;
    debug_pkg::dm_addr_t   dm_addr;
    logic                  rb_re;
    debug_pkg::rb_addr_t   rb_addr;
    debug_pkg::byte_t      tx_data;
    logic                  tx_start;

    logic [31:0]      rng = 32'h5ab468a1;
    int               tx_wait = 0;    // Cycles left until transmit done
    debug_pkg::byte_t tx_q[$];        // Bytes seen on the transmitter
    debug_pkg::byte_t exp_q[$];
    debug_pkg::byte_t sent_q[$];
    logic [15:0]      im_q[$];        // Address and data of each write
    int               step_count = 0;
    string            cur_test;
    int               tests = 0;
    int               errors = 0;
    int               err_mark = 0;
    int               timeouts = 0;

    tb_clock u_clock (
        .o_clock (clock),
        .o_reset (reset)
    );

    debug_top UUT (
        .i_clock      (clock),
        .i_reset      (reset),
        .i_rx_valid   (rx_valid),
        .i_rx_data    (rx_data),
        .i_halt       (halt),
        .i_pc_value   (pc_value),
        .i_dm_data    (dm_data),
        .i_rb_data    (rb_data),
        .i_tx_done    (tx_done),
        .o_state      (state),
        .o_im_we      (im_we),
        .o_im_data    (im_data),
        .o_im_addr    (im_addr),
        .o_cpu_enable (cpu_enable),
        .o_step       (step),
        .o_step_mode  (step_mode),
        .o_dm_re      (dm_re),
        .o_dm_addr    (dm_addr),
        .o_rb_re      (rb_re),
        .o_rb_addr    (rb_addr),
        .o_tx_data    (tx_data),
        .o_tx_start   (tx_start)
    );

    bind debug_top debug_checker u_checker (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_state      (o_state),
        .i_tx_start   (o_tx_start),
        .i_im_we      (o_im_we),
        .i_cpu_enable (o_cpu_enable),
        .i_step       (o_step)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Data memory byte at address a
    function automatic debug_pkg::byte_t dm_byte(input int a);
        return debug_pkg::byte_t'(a * 7 + 3);
    endfunction

    function automatic debug_pkg::word_t reg_word(input int r);
        return {dm_byte_r(r), dm_byte_r(r + 1), dm_byte_r(r + 2), dm_byte_r(r + 3)};
    endfunction

    function automatic debug_pkg::byte_t dm_byte_r(input int v);
        return debug_pkg::byte_t'(v);
    endfunction

    // Read ports follow the addresses in the same cycle
    assign dm_data = dm_re ? dm_byte(int'(dm_addr)) : '0;    // Zero while not enabled
    assign rb_data = rb_re ? reg_word(int'(rb_addr)) : '0;

    // Transmitter with a random done delay of 1 to 6 cycles
    always @(posedge clock) begin
        tx_done <= 1'b0;
        if (tx_start) begin
            tx_q.push_back(tx_data);
            rng = xorshift(rng);
            tx_wait <= int'(rng % 6) + 1;
        end else if (tx_wait == 1) begin
            tx_done <= 1'b1;
            tx_wait <= 0;
        end else if (tx_wait > 1) begin
            tx_wait <= tx_wait - 1;
        end
    end

    always @(posedge clock) begin
        if (im_we)
            im_q.push_back({im_addr, im_data});
        if (step)
            step_count++;
    end

    task automatic check_val(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
        assert (act === exp)
        else begin
            errors++;
            $display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s: %0d errors", cur_test, errors - err_mark);
    endtask

    task automatic finish_run();
        int chk;
        chk = int'(UUT.u_checker.fail_count);
        $display("tests %0d, errors %0d, timeouts %0d, checker failures %0d",
                 tests, errors, timeouts, chk);
        if (errors == 0 && timeouts == 0 && chk == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    // Samples at the falling edge, where outputs are settled
    task automatic wait_state(input debug_pkg::dbg_state_t s, input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (state != s && n < limit);
        if (state != s) begin
            timeouts++;
            $display("Timeout in test %s: state %s never reached within %0d cycles",
                     cur_test, s.name(), limit);
            finish_run();
        end
    endtask

    task automatic send_byte(input debug_pkg::byte_t b);
        @(posedge clock);
        rx_valid <= 1'b1;
        rx_data  <= b;
        @(posedge clock);
        rx_valid <= 1'b0;
    endtask

    task automatic check_idle_outputs();
        check_val("controls", 32'd0,
                  {tx_start, im_we, cpu_enable, step, step_mode, dm_re, rb_re});
        check_val("state", debug_pkg::IDLE, state);
    endtask

    task automatic add_pc_bytes(input debug_pkg::word_t pc);
        for (int i = 3; i >= 0; i--)
            exp_q.push_back(pc[8*i +: 8]);    // Most significant first
    endtask

    task automatic add_dm_bytes();
        for (int a = 0; a < `DBG_DM_DEPTH; a++)
            exp_q.push_back(debug_pkg::byte_t'(a * 7 + 3));
    endtask

    task automatic add_rb_bytes();
        for (int r = 0; r < `DBG_RB_DEPTH; r++)
            for (int k = 0; k < `DBG_WORD_BYTES; k++)
                exp_q.push_back(debug_pkg::byte_t'(r + k));
    endtask

    task automatic compare_stream();
        check_val("byte count", exp_q.size(), tx_q.size());
        for (int i = 0; i < exp_q.size() && i < tx_q.size(); i++)
            check_val($sformatf("byte %0d", i), exp_q[i], tx_q[i]);
    endtask

    task automatic run_dump(input string name, input debug_pkg::byte_t cmd,
                            input debug_pkg::dbg_state_t dump_state);
        begin_test(name);
        tx_q.delete();
        exp_q.delete();
        send_byte(cmd);
        case (dump_state)
            debug_pkg::DUMP_PC: add_pc_bytes(pc_value);
            debug_pkg::DUMP_DM: add_dm_bytes();
            default:            add_rb_bytes();
        endcase
        wait_state(dump_state, 4);
        wait_state(debug_pkg::IDLE, DUMP_LIMIT);
        compare_stream();
        end_test();
    endtask

    initial begin
        rx_valid = 1'b0;
        rx_data  = '0;
        halt     = 1'b0;
        pc_value = '0;
        tx_done  = 1'b0;

        begin_test("reset");
        @(posedge clock);
        @(negedge clock);
        check_idle_outputs();
        for (int n = 0; reset && n < 10; n++)
            @(negedge clock);
        check_val("reset released", 32'd0, reset);
        check_idle_outputs();
        send_byte(8'h5A);    // No such command
        @(negedge clock);
        check_val("state after unknown code", debug_pkg::IDLE, state);
        end_test();

        @(posedge clock);
        pc_value <= 32'h8A3C_51E7;
        run_dump("dump_pc", `DBG_CMD_SEND_PC, debug_pkg::DUMP_PC);
        run_dump("dump_mem", `DBG_CMD_SEND_MEM, debug_pkg::DUMP_DM);
        run_dump("dump_regs", `DBG_CMD_SEND_REGS, debug_pkg::DUMP_RB);

        begin_test("load");
        im_q.delete();
        sent_q.delete();
        send_byte(`DBG_CMD_LOAD);
        wait_state(debug_pkg::LOAD_IM, 4);
        for (int i = 0; i < `DBG_IM_DEPTH; i++) begin
            rng = xorshift(rng);
            sent_q.push_back(debug_pkg::byte_t'(rng));
            send_byte(debug_pkg::byte_t'(rng));
        end
        wait_state(debug_pkg::READY, 8);
        check_val("write count", `DBG_IM_DEPTH, im_q.size());
        for (int i = 0; i < im_q.size() && i < sent_q.size(); i++) begin
            check_val($sformatf("address %0d", i), i, im_q[i][15:8]);
            check_val($sformatf("data %0d", i), sent_q[i], im_q[i][7:0]);
        end
        end_test();

        begin_test("run_halt");
        send_byte(`DBG_CMD_RUN);
        wait_state(debug_pkg::RUN, 4);
        repeat (5) begin
            @(negedge clock);
            check_val("cpu enable while running", 32'd1, cpu_enable);
        end
        @(posedge clock);
        halt <= 1'b1;
        @(negedge clock);
        check_val("cpu enable at halt", 32'd1, cpu_enable);
        @(posedge clock);
        halt <= 1'b0;
        @(negedge clock);
        check_val("state after halt", debug_pkg::IDLE, state);
        check_val("cpu enable after halt", 32'd0, cpu_enable);
        end_test();

        begin_test("step");
        send_byte(`DBG_CMD_STEP_MODE);
        wait_state(debug_pkg::STEP_MODE, 4);
        check_val("step mode", 32'd1, step_mode);
        rng = xorshift(rng);
        @(posedge clock);
        pc_value <= rng;
        tx_q.delete();
        exp_q.delete();
        step_count = 0;
        send_byte(`DBG_CMD_STEP);
        wait_state(debug_pkg::DUMP_PC, 4);
        add_pc_bytes(pc_value);
        add_dm_bytes();
        add_rb_bytes();
        wait_state(debug_pkg::STEP_MODE, CHAIN_LIMIT);
        check_val("step pulses", 32'd1, step_count);
        compare_stream();
        send_byte(`DBG_CMD_CONTINUE);
        wait_state(debug_pkg::RUN, 4);
        check_val("cpu enable after continue", 32'd1, cpu_enable);
        end_test();

        finish_run();
    end

endmodule

`default_nettype wire
